// File: sim.f
+incdir+rtl
rtl/kcpu_pkg.sv
rtl/kcpu_alu.sv
rtl/kcpu_branch.sv
rtl/kcpu_regs.sv
rtl/kcpu_pshpul.sv
rtl/kcpu_ctrl.sv
rtl/kcpu_top.sv
verif/kcpu_asserts.sv
verif/kcpu_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = kcpu_tb
FILELIST  = sim.f
SIM_ARGS  = +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf obj_dir

// File: verif/kcpu_tb.sv
`timescale 1ns/1ps
`include "kcpu_settings.svh"

module kcpu_tb;

localparam int CLK_PERIOD   = 20;
localparam int RESET_CYCLES = 2;
// unstalled cycles of the whole program, rounded up
localparam int PROG_CYCLES  = 400;
// an 8-bit maximal LFSR gives at most 8 ones in a row
localparam int BUSY_STRETCH = 9;
localparam int WATCHDOG_NS  = (RESET_CYCLES + PROG_CYCLES * BUSY_STRETCH) * CLK_PERIOD;

logic                clk = 1'b0;
logic                rst;
logic [`KCPU_AW-1:0] mem_addr;
logic [`KCPU_DW-1:0] mem_wdata;
logic                mem_rd;
logic                mem_wr;
logic                halted;
logic [`KCPU_DW-1:0] mem_rdata;
logic                mem_busy;

logic [`KCPU_DW-1:0] mem [0:255];
logic [7:0]          lfsr = 8'd18;
logic                rd_acc = 1'b0;
logic [`KCPU_AW-1:0] rd_addr;
logic                seen_read = 1'b0;
int                  load_at;
int                  wr_idx = 0;
logic [`KCPU_AW-1:0] exp_addr [$];
logic [`KCPU_DW-1:0] exp_data [$];

always #(CLK_PERIOD / 2) clk = ~clk;

kcpu_top u_kcpu_top (
    .clk       ( clk       ),
    .rst       ( rst       ),
    .mem_addr  ( mem_addr  ),
    .mem_wdata ( mem_wdata ),
    .mem_rd    ( mem_rd    ),
    .mem_wr    ( mem_wr    ),
    .halted    ( halted    ),
    .mem_rdata ( mem_rdata ),
    .mem_busy  ( mem_busy  )
);

task automatic report_fail(input string msg);
    $display("[ERROR] %0d ns: %s", $time, msg);
    $display("sim failed");
    $fatal(1, "stopping at first error");
endtask

// galois form, taps for x^8 + x^6 + x^5 + x^4 + 1
function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return s[0] ? (s >> 1) ^ 8'hB8 : s >> 1;
endfunction

task automatic put_op(input logic [7:0] op);
    mem[load_at[7:0]] = op;
    load_at++;
endtask

task automatic put_op2(input logic [7:0] op, input logic [7:0] arg);
    put_op(op);
    put_op(arg);
endtask

task automatic expect_write(input logic [7:0] addr, input logic [7:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
endtask

task automatic check_write(input logic [7:0] addr, input logic [7:0] data);
    assert (wr_idx < exp_addr.size())
        else report_fail($sformatf("extra write of %02h to %02h", data, addr));
    assert (addr == exp_addr[wr_idx] && data == exp_data[wr_idx])
        else report_fail($sformatf("write %0d: got %02h at %02h, expected %02h at %02h",
                                   wr_idx, data, addr, exp_data[wr_idx], exp_addr[wr_idx]));
    wr_idx++;
endtask

// memory model, one bus cycle per falling edge
always @(negedge clk) begin : bus_model
    logic busy;
    // data phase of a read accepted at the last rising edge
    if (rd_acc) begin
        mem_rdata = mem[rd_addr];
    end
    rd_acc = 1'b0;
    busy = lfsr[0];
    lfsr = lfsr_next(lfsr);
    assert (u_kcpu_top.u_asserts.fail_cnt == 0)
        else report_fail("a bus protocol assertion failed");
    if (halted) begin
        assert (!mem_rd && !mem_wr) else report_fail("request raised after halt");
    end
    if (mem_rd && !busy) begin
        if (!seen_read) begin
            assert (mem_addr == `KCPU_RESET_PC)
                else report_fail($sformatf("first read at %02h", mem_addr));
            seen_read = 1'b1;
        end
        rd_acc  = 1'b1;
        rd_addr = mem_addr;
    end
    if (mem_wr && !busy) begin
        check_write(mem_addr, mem_wdata);
        mem[mem_addr] = mem_wdata;
    end
    mem_busy = busy;
end

initial begin
    #(WATCHDOG_NS);
    $display("timeout: core did not halt within %0d ns", WATCHDOG_NS);
    $display("sim failed");
    $fatal(1, "watchdog expired");
end

initial begin
    rst       = 1'b1;
    mem_rdata = '0;
    mem_busy  = 1'b0;
    for (int i = 0; i < 256; i++) begin
        mem[i] = 8'(i) ^ 8'h5C;
    end
    load_at = 0;
    // immediate loads and stores
    put_op2(8'h00, 8'h5A);
    put_op2(8'h30, 8'h80);
    put_op2(8'h10, 8'hC3);
    put_op2(8'h40, 8'h81);
    // add sets carry, so bcs skips the marker at 90
    put_op(8'h20);
    put_op2(8'h30, 8'h82);
    put_op2(8'h53, 8'h02);
    put_op2(8'h30, 8'h90);
    put_op(8'h21);
    put_op2(8'h30, 8'h83);
    put_op(8'h22);
    put_op2(8'h30, 8'h84);
    // eor gives a negative result, bmi skips 91
    put_op(8'h23);
    put_op2(8'h30, 8'h85);
    put_op2(8'h55, 8'h02);
    put_op2(8'h30, 8'h91);
    put_op(8'h24);
    put_op2(8'h30, 8'h86);
    // branch paths, markers in the 9x range
    put_op2(8'h53, 8'h02);
    put_op2(8'h30, 8'h92);
    put_op(8'h23);
    put_op2(8'h51, 8'h02);
    put_op2(8'h30, 8'h93);
    put_op2(8'h52, 8'h02);
    put_op2(8'h40, 8'h94);
    put_op2(8'h00, 8'h7E);
    put_op2(8'h52, 8'h02);
    put_op2(8'h30, 8'h95);
    put_op2(8'h51, 8'h02);
    put_op2(8'h30, 8'h96);
    put_op2(8'h55, 8'h02);
    put_op2(8'h30, 8'h97);
    put_op2(8'h50, 8'h02);
    put_op2(8'h30, 8'h98);
    // cc = 06 before the push (N and C set)
    put_op2(8'h00, 8'hFF);
    put_op2(8'h10, 8'h01);
    put_op(8'h20);
    put_op2(8'h00, 8'hA5);
    put_op2(8'h60, 8'h07);
    put_op2(8'h00, 8'h00);
    put_op2(8'h10, 8'h33);
    // and clears C, so the clobbered cc has neither N nor C
    put_op(8'h22);
    put_op2(8'h70, 8'h07);
    put_op2(8'h30, 8'hA0);
    put_op2(8'h40, 8'hA1);
    // both only taken with the pulled cc
    put_op2(8'h55, 8'h02);
    put_op2(8'h30, 8'h9A);
    put_op2(8'h53, 8'h02);
    put_op2(8'h30, 8'h9B);
    put_op(8'hF0);

    expect_write(8'h80, 8'h5A);
    expect_write(8'h81, 8'hC3);
    expect_write(8'h82, 8'h1D);
    expect_write(8'h83, 8'h5A);
    expect_write(8'h84, 8'h42);
    expect_write(8'h85, 8'h81);
    expect_write(8'h86, 8'hC3);
    expect_write(8'h92, 8'hC3);
    expect_write(8'h94, 8'hC3);
    expect_write(8'h96, 8'h7E);
    expect_write(8'h97, 8'h7E);
    // push order cc, B, A going down from the stack top
    expect_write(8'hFF, 8'h06);
    expect_write(8'hFE, 8'h01);
    expect_write(8'hFD, 8'hA5);
    expect_write(8'hA0, 8'hA5);
    expect_write(8'hA1, 8'h01);

    repeat (RESET_CYCLES) begin
        @(negedge clk);
        assert (!mem_rd && !mem_wr && !halted)
            else report_fail("request or halt raised during reset");
    end
    rst = 1'b0;
    assert (!mem_rd && !mem_wr && !halted)
        else report_fail("request or halt raised right after reset");

    while (!halted) begin
        @(negedge clk);
    end
    // a few idle cycles so the halt checks see the bus stay quiet
    repeat (8) @(negedge clk);
    if (wr_idx == exp_addr.size() && u_kcpu_top.u_asserts.fail_cnt == 0) begin
        $display("sim passed");
        $finish;
    end else begin
        report_fail($sformatf("halted after %0d of %0d expected writes",
                              wr_idx, exp_addr.size()));
    end
end

endmodule

// File: verif/kcpu_asserts.sv
`timescale 1ns/1ps
`include "kcpu_settings.svh"

module kcpu_asserts (
    input logic                clk,
    input logic                rst,
    input logic [`KCPU_AW-1:0] mem_addr,
    input logic [`KCPU_DW-1:0] mem_wdata,
    input logic                mem_rd,
    input logic                mem_wr,
    input logic                mem_busy,
    input logic                halted
);

// count of failed properties, read by the testbench
int   fail_cnt = 0;
logic seen_rd;

// set once the first read has been accepted
always_ff @(posedge clk) begin
    if (rst) begin
        seen_rd <= 1'b0;
    end else if (mem_rd && !mem_busy) begin
        seen_rd <= 1'b1;
    end
end

// no request and no halt while in reset or right after it
a_reset_idle: assert property (@(posedge clk)
    rst |=> !mem_rd && !mem_wr && !halted)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("bus active during or right after reset");
    end

a_first_read: assert property (@(posedge clk) disable iff (rst)
    mem_rd && !seen_rd |-> mem_addr == `KCPU_RESET_PC)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("first fetch not at the reset pc");
    end

// request and address frozen under back-pressure
a_req_hold: assert property (@(posedge clk) disable iff (rst)
    (mem_rd || mem_wr) && mem_busy |=>
        $stable(mem_rd) && $stable(mem_wr) && $stable(mem_addr))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("request changed while busy");
    end

a_wdata_hold: assert property (@(posedge clk) disable iff (rst)
    mem_wr && mem_busy |=> $stable(mem_wdata))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("write data changed while busy");
    end

a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
    !(mem_rd && mem_wr))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("read and write raised together");
    end

a_halt_sticky: assert property (@(posedge clk) disable iff (rst)
    halted |=> halted)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("halted dropped without reset");
    end

a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
    halted |-> !mem_rd && !mem_wr)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("bus request while halted");
    end

endmodule

bind kcpu_top kcpu_asserts u_asserts (
    .clk       ( clk       ),
    .rst       ( rst       ),
    .mem_addr  ( mem_addr  ),
    .mem_wdata ( mem_wdata ),
    .mem_rd    ( mem_rd    ),
    .mem_wr    ( mem_wr    ),
    .mem_busy  ( mem_busy  ),
    .halted    ( halted    )
);

// File: rtl/kcpu_top.sv
`timescale 1ns/1ps
`include "kcpu_settings.svh"

module kcpu_top
    import kcpu_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    output logic [`KCPU_AW-1:0] mem_addr,
    output logic [`KCPU_DW-1:0] mem_wdata,
    output logic                mem_rd,
    output logic                mem_wr,
    output logic                halted,
    input  logic [`KCPU_DW-1:0] mem_rdata,
    input  logic                mem_busy
);

logic [`KCPU_DW-1:0] a;
logic [`KCPU_DW-1:0] b;
logic [`KCPU_DW-1:0] cc;
logic [`KCPU_DW-1:0] result;
logic [`KCPU_DW-1:0] flags_n;
logic [`KCPU_DW-1:0] stk_mask;
logic [`KCPU_AW-1:0] sp_addr;
logic [2:0]          stk_sel;
instr_u              ir;
alu_fn_e             alu_fn;
logic                taken;
logic                ld_a;
logic                ld_b;
logic                alu_we;
logic                pul_we;
logic                stk_start;
logic                stk_pull;
logic                stk_step;
logic                stk_busy;

kcpu_ctrl u_ctrl (
    .clk       ( clk       ),
    .rst       ( rst       ),
    .mem_rdata ( mem_rdata ),
    .mem_busy  ( mem_busy  ),
    .a         ( a         ),
    .b         ( b         ),
    .cc        ( cc        ),
    .taken     ( taken     ),
    .sp_addr   ( sp_addr   ),
    .stk_sel   ( stk_sel   ),
    .stk_busy  ( stk_busy  ),
    .mem_addr  ( mem_addr  ),
    .mem_rd    ( mem_rd    ),
    .mem_wr    ( mem_wr    ),
    .mem_wdata ( mem_wdata ),
    .halted    ( halted    ),
    .ir        ( ir        ),
    .ld_a      ( ld_a      ),
    .ld_b      ( ld_b      ),
    .alu_we    ( alu_we    ),
    .alu_fn    ( alu_fn    ),
    .pul_we    ( pul_we    ),
    .stk_start ( stk_start ),
    .stk_pull  ( stk_pull  ),
    .stk_mask  ( stk_mask  ),
    .stk_step  ( stk_step  )
);

kcpu_branch u_branch (
    .ir    ( ir    ),
    .cc    ( cc    ),
    .taken ( taken )
);

kcpu_regs u_regs (
    .clk       ( clk       ),
    .rst       ( rst       ),
    .ld_a      ( ld_a      ),
    .ld_b      ( ld_b      ),
    .alu_we    ( alu_we    ),
    .pul_we    ( pul_we    ),
    .stk_sel   ( stk_sel   ),
    .mem_rdata ( mem_rdata ),
    .result    ( result    ),
    .flags_n   ( flags_n   ),
    .a         ( a         ),
    .b         ( b         ),
    .cc        ( cc        )
);

kcpu_alu u_alu (
    .a       ( a       ),
    .b       ( b       ),
    .alu_fn  ( alu_fn  ),
    .result  ( result  ),
    .flags_n ( flags_n )
);

kcpu_pshpul u_pshpul (
    .clk       ( clk       ),
    .rst       ( rst       ),
    .stk_start ( stk_start ),
    .stk_pull  ( stk_pull  ),
    .stk_mask  ( stk_mask  ),
    .stk_step  ( stk_step  ),
    .sp_addr   ( sp_addr   ),
    .stk_sel   ( stk_sel   ),
    .stk_busy  ( stk_busy  )
);

endmodule

// File: rtl/kcpu_ctrl.sv
`timescale 1ns/1ps
`include "kcpu_settings.svh"

module kcpu_ctrl
    import kcpu_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [`KCPU_DW-1:0] mem_rdata,
    input  logic                mem_busy,
    input  logic [`KCPU_DW-1:0] a,
    input  logic [`KCPU_DW-1:0] b,
    input  logic [`KCPU_DW-1:0] cc,
    input  logic                taken,
    input  logic [`KCPU_AW-1:0] sp_addr,
    input  logic [2:0]          stk_sel,
    input  logic                stk_busy,
    output logic [`KCPU_AW-1:0] mem_addr,
    output logic                mem_rd,
    output logic                mem_wr,
    output logic [`KCPU_DW-1:0] mem_wdata,
    output logic                halted,
    output instr_u              ir,
    output logic                ld_a,
    output logic                ld_b,
    output logic                alu_we,
    output alu_fn_e             alu_fn,
    output logic                pul_we,
    output logic                stk_start,
    output logic                stk_pull,
    output logic [`KCPU_DW-1:0] stk_mask,
    output logic                stk_step
);

localparam logic [2:0] S_FETCH   = 3'd0;
localparam logic [2:0] S_OPERAND = 3'd1;
localparam logic [2:0] S_EXEC    = 3'd2;
localparam logic [2:0] S_STACK   = 3'd3;
localparam logic [2:0] S_HALT    = 3'd4;

logic [2:0]          state;
logic                run;
// data phase, the cycle after an accepted access
logic                pend;
logic [`KCPU_AW-1:0] pc;
logic [`KCPU_DW-1:0] opnd;
instr_u              opc;
grp_e                grp;
logic                is_st;
logic                accept;

assign opc    = mem_rdata;
assign grp    = ir.alu_view.grp;
assign alu_fn = ir.alu_view.fn;
assign is_st  = grp == GRP_STA || grp == GRP_STB;
assign accept = (mem_rd | mem_wr) & ~mem_busy;

// bus requests, held steady until accepted
always_comb begin
    mem_rd   = 1'b0;
    mem_wr   = 1'b0;
    mem_addr = pc;
    if (state == S_EXEC) begin
        mem_addr = opnd;
    end else if (state == S_STACK) begin
        mem_addr = sp_addr;
    end
    if (run && !pend) begin
        case (state)
            S_FETCH, S_OPERAND: mem_rd = 1'b1;
            S_EXEC:             mem_wr = is_st;
            S_STACK: begin
                mem_rd = stk_busy & stk_pull;
                mem_wr = stk_busy & ~stk_pull;
            end
            default: ;
        endcase
    end
end

// push order follows stk_sel, stores pick by opcode
always_comb begin
    if (state == S_STACK) begin
        mem_wdata = stk_sel[MASK_CC] ? cc : stk_sel[MASK_B] ? b : a;
    end else begin
        mem_wdata = grp == GRP_STB ? b : a;
    end
end

assign ld_a      = state == S_OPERAND && pend && grp == GRP_LDA;
assign ld_b      = state == S_OPERAND && pend && grp == GRP_LDB;
assign alu_we    = state == S_EXEC && grp == GRP_ALU;
assign stk_start = state == S_EXEC && (grp == GRP_PSH || grp == GRP_PUL);
assign stk_pull  = grp == GRP_PUL;
assign stk_mask  = opnd;
assign stk_step  = state == S_STACK && pend;
assign pul_we    = stk_step && stk_pull;
assign halted    = state == S_HALT;

always_ff @(posedge clk) begin
    if (rst) begin
        state <= S_FETCH;
        run   <= 1'b0;
        pend  <= 1'b0;
        pc    <= `KCPU_RESET_PC;
    end else begin
        run <= 1'b1;
        if (accept) begin
            pend <= 1'b1;
        end
        case (state)
            S_FETCH: begin
                if (accept) begin
                    pc <= pc + 1'b1;
                end
                if (pend) begin
                    pend <= 1'b0;
                    case (opc.alu_view.grp)
                        GRP_HALT: state <= S_HALT;
                        GRP_ALU:  state <= S_EXEC;
                        default:  state <= S_OPERAND;
                    endcase
                end
            end
            S_OPERAND: begin
                if (accept) begin
                    pc <= pc + 1'b1;
                end
                if (pend) begin
                    pend <= 1'b0;
                    // pc already points past the offset byte
                    if (taken) begin
                        pc <= pc + mem_rdata;
                    end
                    if (is_st || grp == GRP_PSH || grp == GRP_PUL) begin
                        state <= S_EXEC;
                    end else begin
                        state <= S_FETCH;
                    end
                end
            end
            S_EXEC: begin
                if (!is_st) begin
                    state <= stk_start ? S_STACK : S_FETCH;
                end else if (pend) begin
                    pend  <= 1'b0;
                    state <= S_FETCH;
                end
            end
            S_STACK: begin
                if (pend) begin
                    pend <= 1'b0;
                end else if (!stk_busy) begin
                    state <= S_FETCH;
                end
            end
            S_HALT: ;
            default: state <= S_FETCH;
        endcase
    end
end

// opcode and operand bytes
always_ff @(posedge clk) begin
    if (state == S_FETCH && pend) begin
        ir <= opc;
    end
    if (state == S_OPERAND && pend) begin
        opnd <= mem_rdata;
    end
end

endmodule

// File: rtl/kcpu_pshpul.sv
`timescale 1ns/1ps
`include "kcpu_settings.svh"

module kcpu_pshpul
    import kcpu_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                stk_start,
    input  logic                stk_pull,
    input  logic [`KCPU_DW-1:0] stk_mask,
    input  logic                stk_step,
    output logic [`KCPU_AW-1:0] sp_addr,
    output logic [2:0]          stk_sel,
    output logic                stk_busy
);

logic [`KCPU_AW-1:0] sp;
// registers still to transfer
logic [2:0]          left;

assign stk_busy = |left;

// pull pre-increments, push uses sp as is
assign sp_addr = stk_pull ? sp + 1'b1 : sp;

always_comb begin
    stk_sel = '0;
    if (stk_pull) begin
        // A, B, then cc
        if (left[MASK_A]) begin
            stk_sel[MASK_A] = 1'b1;
        end else if (left[MASK_B]) begin
            stk_sel[MASK_B] = 1'b1;
        end else if (left[MASK_CC]) begin
            stk_sel[MASK_CC] = 1'b1;
        end
    end else begin
        // cc, B, then A
        if (left[MASK_CC]) begin
            stk_sel[MASK_CC] = 1'b1;
        end else if (left[MASK_B]) begin
            stk_sel[MASK_B] = 1'b1;
        end else if (left[MASK_A]) begin
            stk_sel[MASK_A] = 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        sp   <= `KCPU_STACK_TOP;
        left <= '0;
    end else if (stk_start) begin
        left <= stk_mask[MASK_CC:MASK_A];
    end else if (stk_step) begin
        left <= left & ~stk_sel;
        sp   <= stk_pull ? sp_addr : sp - 1'b1;
    end
end

endmodule

// File: rtl/kcpu_regs.sv
`timescale 1ns/1ps
`include "kcpu_settings.svh"

module kcpu_regs
    import kcpu_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                ld_a,
    input  logic                ld_b,
    input  logic                alu_we,
    input  logic                pul_we,
    input  logic [2:0]          stk_sel,
    input  logic [`KCPU_DW-1:0] mem_rdata,
    input  logic [`KCPU_DW-1:0] result,
    input  logic [`KCPU_DW-1:0] flags_n,
    output logic [`KCPU_DW-1:0] a,
    output logic [`KCPU_DW-1:0] b,
    output logic [`KCPU_DW-1:0] cc
);

logic [`KCPU_DW-1:0] ld_flags;
logic [`KCPU_DW-1:0] cc_pull;

always_comb begin
    // loads keep C
    ld_flags       = cc;
    ld_flags[CC_Z] = mem_rdata == '0;
    ld_flags[CC_N] = mem_rdata[`KCPU_DW-1];
    // unused cc bits stay zero on a pull
    cc_pull        = '0;
    cc_pull[CC_Z]  = mem_rdata[CC_Z];
    cc_pull[CC_N]  = mem_rdata[CC_N];
    cc_pull[CC_C]  = mem_rdata[CC_C];
end

always_ff @(posedge clk) begin
    if (rst) begin
        a  <= '0;
        b  <= '0;
        cc <= '0;
    end else begin
        if (ld_a) begin
            a  <= mem_rdata;
            cc <= ld_flags;
        end
        if (ld_b) begin
            b  <= mem_rdata;
            cc <= ld_flags;
        end
        if (alu_we) begin
            a  <= result;
            cc <= flags_n;
        end
        if (pul_we) begin
            if (stk_sel[MASK_A]) begin
                a <= mem_rdata;
            end
            if (stk_sel[MASK_B]) begin
                b <= mem_rdata;
            end
            if (stk_sel[MASK_CC]) begin
                cc <= cc_pull;
            end
        end
    end
end

endmodule

// File: rtl/kcpu_branch.sv
`timescale 1ns/1ps
`include "kcpu_settings.svh"

module kcpu_branch
    import kcpu_pkg::*;
(
    input  instr_u              ir,
    input  logic [`KCPU_DW-1:0] cc,
    output logic                taken
);

logic hit;

always_comb begin
    case (ir.br_view.cond)
        COND_ALW: hit = 1'b1;
        COND_EQ:  hit = cc[CC_Z];
        COND_NE:  hit = ~cc[CC_Z];
        COND_CS:  hit = cc[CC_C];
        COND_CC:  hit = ~cc[CC_C];
        COND_MI:  hit = cc[CC_N];
        COND_PL:  hit = ~cc[CC_N];
        default:  hit = 1'b0;
    endcase
end

// only a BR opcode can branch
assign taken = hit && ir.br_view.grp == GRP_BR;

endmodule

// File: rtl/kcpu_alu.sv
`timescale 1ns/1ps
`include "kcpu_settings.svh"

module kcpu_alu
    import kcpu_pkg::*;
(
    input  logic [`KCPU_DW-1:0] a,
    input  logic [`KCPU_DW-1:0] b,
    input  alu_fn_e             alu_fn,
    output logic [`KCPU_DW-1:0] result,
    output logic [`KCPU_DW-1:0] flags_n
);

// extra top bit holds carry or borrow
logic [`KCPU_DW:0] sum;

always_comb begin
    case (alu_fn)
        FN_ADD: begin
            sum = {1'b0, a} + {1'b0, b};
        end
        FN_SUB: begin
            // wraps into the top bit when b > a
            sum = {1'b0, a} - {1'b0, b};
        end
        FN_AND: begin
            sum = {1'b0, a & b};
        end
        FN_EOR: begin
            sum = {1'b0, a ^ b};
        end
        FN_TBA: begin
            sum = {1'b0, b};
        end
        default: begin
            sum = {1'b0, a};
        end
    endcase
end

assign result = sum[`KCPU_DW-1:0];

always_comb begin
    flags_n       = '0;
    flags_n[CC_Z] = result == '0;
    flags_n[CC_N] = result[`KCPU_DW-1];
    // zero for the logic functions
    flags_n[CC_C] = sum[`KCPU_DW];
end

endmodule

// File: rtl/kcpu_pkg.sv
package kcpu_pkg;

    // opcode upper nibble
    typedef enum logic [3:0] {
        GRP_LDA  = 4'h0,
        GRP_LDB  = 4'h1,
        GRP_ALU  = 4'h2,
        GRP_STA  = 4'h3,
        GRP_STB  = 4'h4,
        GRP_BR   = 4'h5,
        GRP_PSH  = 4'h6,
        GRP_PUL  = 4'h7,
        GRP_HALT = 4'hF
    } grp_e;

    // ALU functions, result always goes to A
    typedef enum logic [3:0] {
        FN_ADD = 4'h0,
        FN_SUB = 4'h1,
        FN_AND = 4'h2,
        FN_EOR = 4'h3,
        FN_TBA = 4'h4
    } alu_fn_e;

    // branch conditions
    typedef enum logic [3:0] {
        COND_ALW = 4'h0,
        COND_EQ  = 4'h1,
        COND_NE  = 4'h2,
        COND_CS  = 4'h3,
        COND_CC  = 4'h4,
        COND_MI  = 4'h5,
        COND_PL  = 4'h6
    } cond_e;

    // flag positions in cc
    localparam int CC_Z = 0;
    localparam int CC_N = 1;
    localparam int CC_C = 2;

    // push/pull mask bits
    localparam int MASK_A  = 0;
    localparam int MASK_B  = 1;
    localparam int MASK_CC = 2;

    typedef struct packed {
        grp_e    grp;
        alu_fn_e fn;
    } alu_view_t;

    typedef struct packed {
        grp_e  grp;
        cond_e cond;
    } br_view_t;

    // one opcode byte, two decodes of the low nibble
    typedef union packed {
        alu_view_t alu_view;
        br_view_t  br_view;
    } instr_u;

endpackage

// File: rtl/kcpu_settings.svh
`ifndef KCPU_SETTINGS_SVH
`define KCPU_SETTINGS_SVH

// data path and memory bus widths
`define KCPU_DW 8
`define KCPU_AW 8

// address of the first opcode fetch
`define KCPU_RESET_PC 8'h00

// stack grows downward, pointer decrements after each push
`define KCPU_STACK_TOP 8'hFF

`endif
